//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = lsu_cluster_tb
FLIST   = lsu_cluster.f
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- design/lsu_agu.sv
`include "lsu_consts.svh"

module lsu_agu (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      flush_i,
    input  logic                      issue_valid_i,
    input  lsu_types_pkg::lsu_issue_t issue_i,
    input  logic                      pipe_ready_i,
    output logic                      issue_ready_o,
    output logic                      mem_valid_o,
    output lsu_types_pkg::mem_req_t   mem_req_o,
    output lsu_types_pkg::lsu_tag_t   tag_o
);

localparam int AW = $clog2(`LSU_RAM_WORDS);

logic [`LSU_XLEN-1:0]    addr;
logic                    is_store;
logic                    misalign;
lsu_types_pkg::mem_req_t req;
lsu_types_pkg::lsu_tag_t tag;

assign issue_ready_o = !mem_valid_o || pipe_ready_i;
assign addr = issue_i.base + issue_i.imm;

// strobe, lane data and alignment per opcode
always_comb begin
    is_store  = 1'b0;
    misalign  = 1'b0;
    req.addr  = addr[AW+1:2];
    req.strb  = '0;
    req.wdata = issue_i.sdata;
    unique case (issue_i.op)
        lsu_ctrl_pkg::OP_LH, lsu_ctrl_pkg::OP_LHU: misalign = addr[0];
        lsu_ctrl_pkg::OP_LW: misalign = |addr[1:0];
        lsu_ctrl_pkg::OP_SB: begin
            is_store  = 1'b1;
            req.strb  = 4'b0001 << addr[1:0];
            req.wdata = {4{issue_i.sdata[7:0]}};
        end
        lsu_ctrl_pkg::OP_SH: begin
            is_store  = 1'b1;
            misalign  = addr[0];
            req.strb  = 4'b0011 << {addr[1], 1'b0};
            req.wdata = {2{issue_i.sdata[15:0]}};
        end
        lsu_ctrl_pkg::OP_SW: begin
            is_store = 1'b1;
            misalign = |addr[1:0];
            req.strb = 4'b1111;
        end
        default: ;
    endcase
    // misaligned ops never touch memory
    req.we = is_store && !misalign;
    if (misalign) begin
        req.strb = '0;
    end

    tag.op         = issue_i.op;
    tag.rob_id     = issue_i.rob_id;
    tag.offset     = addr[1:0];
    tag.fault_addr = addr;
    if (!misalign) begin
        tag.exc = lsu_ctrl_pkg::EXC_NONE;
    end else if (is_store) begin
        tag.exc = lsu_ctrl_pkg::EXC_STORE_MISALIGN;
    end else begin
        tag.exc = lsu_ctrl_pkg::EXC_LOAD_MISALIGN;
    end
end

always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
        mem_valid_o <= 1'b0;
    end else if (issue_ready_o) begin
        mem_valid_o <= issue_valid_i;
    end
end

always_ff @(posedge clk) begin
    if (issue_ready_o && issue_valid_i) begin
        mem_req_o <= req;
        tag_o     <= tag;
    end
end

endmodule

//--- design/lsu_cluster.sv
`include "lsu_consts.svh"

module lsu_cluster (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         dispatch_valid_i,
    output logic                         dispatch_ready_o,
    input  lsu_types_pkg::lsu_dispatch_t dispatch_i,
    input  lsu_types_pkg::cdb_t          wakeup_i,
    output logic                         result_valid_o,
    input  logic                         result_ready_i,
    output lsu_types_pkg::cdb_t          result_o,
    output lsu_ctrl_pkg::exc_code_e      result_exc_o
);

logic                      issue_valid;
logic                      issue_ready;
lsu_types_pkg::lsu_issue_t issue;
logic                      mem_valid;
lsu_types_pkg::mem_req_t   mem_req;
lsu_types_pkg::lsu_tag_t   tag;
logic                      pipe_ready;
logic                      mem_fire;
logic [`LSU_XLEN-1:0]      rdata;
logic                      tag_full;
logic                      tag_head_valid;
lsu_types_pkg::lsu_tag_t   tag_head;
logic                      tag_pop;
logic                      ram_hold;

// the single read register cannot take a new word while the result stalls
assign pipe_ready = !tag_full && !ram_hold;
assign mem_fire   = mem_valid && pipe_ready && !flush_i;

lsu_issue_queue u_iq (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_ready_o (dispatch_ready_o),
    .dispatch_i       (dispatch_i),
    .wakeup_i         (wakeup_i),
    .issue_valid_o    (issue_valid),
    .issue_ready_i    (issue_ready),
    .issue_o          (issue)
);

lsu_agu u_agu (
    .clk           (clk),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .pipe_ready_i  (pipe_ready),
    .issue_ready_o (issue_ready),
    .mem_valid_o   (mem_valid),
    .mem_req_o     (mem_req),
    .tag_o         (tag)
);

// ---------------------------------------------------------
// RAM access and tag queue side by side
// ---------------------------------------------------------
lsu_data_ram u_ram (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (mem_fire),
    .req_i       (mem_req),
    .hold_i      (ram_hold),
    .rdata_o     (rdata)
);

lsu_tag_queue u_tagq (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .push_i       (mem_fire),
    .tag_i        (tag),
    .pop_i        (tag_pop),
    .full_o       (tag_full),
    .head_valid_o (tag_head_valid),
    .head_o       (tag_head)
);

lsu_writeback u_wb (
    .tag_valid_i    (tag_head_valid),
    .tag_i          (tag_head),
    .rdata_i        (rdata),
    .result_ready_i (result_ready_i),
    .tag_pop_o      (tag_pop),
    .ram_hold_o     (ram_hold),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_exc_o   (result_exc_o)
);

endmodule

//--- design/lsu_ctrl_pkg.sv
package lsu_ctrl_pkg;

// memory opcodes, loads first then stores
typedef enum logic [2:0] {
    OP_LB  = 3'd0,
    OP_LH  = 3'd1,
    OP_LW  = 3'd2,
    OP_LBU = 3'd3,
    OP_LHU = 3'd4,
    OP_SB  = 3'd5,
    OP_SH  = 3'd6,
    OP_SW  = 3'd7
} mem_op_e;

// exception reported with a result
typedef enum logic [1:0] {
    EXC_NONE           = 2'd0,
    EXC_LOAD_MISALIGN  = 2'd1,
    EXC_STORE_MISALIGN = 2'd2
} exc_code_e;

endpackage

//--- design/lsu_data_ram.sv
`include "lsu_consts.svh"

module lsu_data_ram (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    req_valid_i,
    input  lsu_types_pkg::mem_req_t req_i,
    input  logic                    hold_i,
    output logic [`LSU_XLEN-1:0]    rdata_o
);

localparam int BYTES = `LSU_XLEN / 8;

logic [`LSU_XLEN-1:0] mem_q [`LSU_RAM_WORDS];

always_ff @(posedge clk) begin
    if (reset_i) begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem_q[i] <= '0;
        end
        rdata_o <= '0;
    end else begin
        // byte lanes written under strobe
        if (req_valid_i && req_i.we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
        // read word keeps its value while the result is stalled
        if (req_valid_i && !hold_i) begin
            rdata_o <= mem_q[req_i.addr];
        end
    end
end

endmodule

//--- design/lsu_issue_queue.sv
`include "lsu_consts.svh"

module lsu_issue_queue (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         dispatch_valid_i,
    output logic                         dispatch_ready_o,
    input  lsu_types_pkg::lsu_dispatch_t dispatch_i,
    input  lsu_types_pkg::cdb_t          wakeup_i,
    output logic                         issue_valid_o,
    input  logic                         issue_ready_i,
    output lsu_types_pkg::lsu_issue_t    issue_o
);

localparam int DEPTH = `LSU_IQ_DEPTH;
localparam int PTR_W = $clog2(DEPTH);

lsu_types_pkg::lsu_dispatch_t entries_q [DEPTH];
lsu_types_pkg::lsu_dispatch_t head_entry;
logic [PTR_W-1:0] head_q;
logic [PTR_W-1:0] tail_q;
logic [PTR_W:0]   count_q;
logic             push;
logic             pop;

// fill in an operand from a matching broadcast
function automatic lsu_types_pkg::operand_t wake(
    input lsu_types_pkg::operand_t opnd,
    input lsu_types_pkg::cdb_t     bus
);
    lsu_types_pkg::operand_t res;
    res = opnd;
    if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
        res.data  = bus.data;
        res.ready = 1'b1;
    end
    return res;
endfunction

// ---------------------------------------------------------
// pointers and occupancy
// ---------------------------------------------------------
assign dispatch_ready_o = (count_q != DEPTH[PTR_W:0]);
assign push = dispatch_valid_i && dispatch_ready_o;
assign pop  = issue_valid_o && issue_ready_i;

always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
        head_q  <= '0;
        tail_q  <= '0;
        count_q <= '0;
    end else begin
        if (push) begin
            tail_q <= tail_q + 1'b1;
        end
        if (pop) begin
            head_q <= head_q + 1'b1;
        end
        count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
end

// ---------------------------------------------------------
// entry storage with wakeup
// ---------------------------------------------------------
always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
        entries_q[i].base  <= wake(entries_q[i].base, wakeup_i);
        entries_q[i].sdata <= wake(entries_q[i].sdata, wakeup_i);
    end
    // a broadcast on the dispatch cycle is caught here
    if (push) begin
        entries_q[tail_q]       <= dispatch_i;
        entries_q[tail_q].base  <= wake(dispatch_i.base, wakeup_i);
        entries_q[tail_q].sdata <= wake(dispatch_i.sdata, wakeup_i);
    end
end

// ---------------------------------------------------------
// in-order issue from the head
// ---------------------------------------------------------
assign head_entry = entries_q[head_q];

assign issue_valid_o = (count_q != '0) && head_entry.base.ready && head_entry.sdata.ready;

always_comb begin
    issue_o.op     = head_entry.op;
    issue_o.rob_id = head_entry.rob_id;
    issue_o.imm    = head_entry.imm;
    issue_o.base   = head_entry.base.data;
    issue_o.sdata  = head_entry.sdata.data;
end

endmodule

//--- design/lsu_tag_queue.sv
`include "lsu_consts.svh"

module lsu_tag_queue (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  lsu_types_pkg::lsu_tag_t tag_i,
    input  logic                    pop_i,
    output logic                    full_o,
    output logic                    head_valid_o,
    output lsu_types_pkg::lsu_tag_t head_o
);

localparam int DEPTH = `LSU_TAGQ_DEPTH;
localparam int PTR_W = $clog2(DEPTH);

lsu_types_pkg::lsu_tag_t fifo_q [DEPTH];
logic [PTR_W-1:0] rd_ptr_q;
logic [PTR_W-1:0] wr_ptr_q;
logic [PTR_W:0]   count_q;
logic             do_push;
logic             do_pop;

assign full_o       = (count_q == DEPTH[PTR_W:0]);
assign head_valid_o = (count_q != '0);
assign head_o       = fifo_q[rd_ptr_q];
assign do_push      = push_i && !full_o;
assign do_pop       = pop_i && head_valid_o;

always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
end

always_ff @(posedge clk) begin
    if (do_push) begin
        fifo_q[wr_ptr_q] <= tag_i;
    end
end

endmodule

//--- design/lsu_types_pkg.sv
`include "lsu_consts.svh"

package lsu_types_pkg;

// one source operand, waits for a CDB tag match when not ready
typedef struct packed {
    logic [`LSU_XLEN-1:0]     data;
    logic [`LSU_ROB_ID_W-1:0] tag;
    logic                     ready;
} operand_t;

typedef struct packed {
    lsu_ctrl_pkg::mem_op_e    op;
    logic [`LSU_ROB_ID_W-1:0] rob_id;
    logic [`LSU_XLEN-1:0]     imm;
    operand_t                 base;
    operand_t                 sdata;
} lsu_dispatch_t;

// operands resolved at issue
typedef struct packed {
    lsu_ctrl_pkg::mem_op_e    op;
    logic [`LSU_ROB_ID_W-1:0] rob_id;
    logic [`LSU_XLEN-1:0]     imm;
    logic [`LSU_XLEN-1:0]     base;
    logic [`LSU_XLEN-1:0]     sdata;
} lsu_issue_t;

typedef struct packed {
    logic [$clog2(`LSU_RAM_WORDS)-1:0] addr;
    logic                              we;
    logic [`LSU_XLEN/8-1:0]            strb;
    logic [`LSU_XLEN-1:0]              wdata;
} mem_req_t;

// kept beside the RAM access until writeback
typedef struct packed {
    lsu_ctrl_pkg::mem_op_e     op;
    logic [`LSU_ROB_ID_W-1:0]  rob_id;
    logic [1:0]                offset;
    lsu_ctrl_pkg::exc_code_e   exc;
    logic [`LSU_XLEN-1:0]      fault_addr;
} lsu_tag_t;

typedef struct packed {
    logic                     valid;
    logic [`LSU_ROB_ID_W-1:0] tag;
    logic [`LSU_XLEN-1:0]     data;
} cdb_t;

endpackage

//--- design/lsu_writeback.sv
`include "lsu_consts.svh"

module lsu_writeback (
    input  logic                     tag_valid_i,
    input  lsu_types_pkg::lsu_tag_t  tag_i,
    input  logic [`LSU_XLEN-1:0]     rdata_i,
    input  logic                     result_ready_i,
    output logic                     tag_pop_o,
    output logic                     ram_hold_o,
    output logic                     result_valid_o,
    output lsu_types_pkg::cdb_t      result_o,
    output lsu_ctrl_pkg::exc_code_e  result_exc_o
);

localparam int XLEN = `LSU_XLEN;

logic [XLEN-1:0] shifted;

// ---------------------------------------------------------
// handshake
// ---------------------------------------------------------
assign result_valid_o = tag_valid_i;
assign tag_pop_o      = tag_valid_i && result_ready_i;
assign ram_hold_o     = tag_valid_i && !result_ready_i;
assign result_exc_o   = tag_i.exc;

// ---------------------------------------------------------
// lane select and extension
// ---------------------------------------------------------
assign shifted = rdata_i >> {tag_i.offset, 3'b000};

always_comb begin
    result_o.valid = tag_valid_i;
    result_o.tag   = tag_i.rob_id;
    unique case (tag_i.op)
        lsu_ctrl_pkg::OP_LB:  result_o.data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
        lsu_ctrl_pkg::OP_LBU: result_o.data = {{(XLEN-8){1'b0}}, shifted[7:0]};
        lsu_ctrl_pkg::OP_LH:  result_o.data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
        lsu_ctrl_pkg::OP_LHU: result_o.data = {{(XLEN-16){1'b0}}, shifted[15:0]};
        lsu_ctrl_pkg::OP_LW:  result_o.data = rdata_i;
        // stores return zero
        default:              result_o.data = '0;
    endcase
    // faulting address replaces the data
    if (tag_i.exc != lsu_ctrl_pkg::EXC_NONE) begin
        result_o.data = tag_i.fault_addr;
    end
end

endmodule

//--- include/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data path
`define LSU_XLEN        32
`define LSU_ROB_ID_W    5

// queue sizes
`define LSU_IQ_DEPTH    8
`define LSU_TAGQ_DEPTH  4

// data RAM size in words
`define LSU_RAM_WORDS   64

`endif

//--- lsu_cluster.f
+incdir+include
design/lsu_ctrl_pkg.sv
design/lsu_types_pkg.sv
design/lsu_issue_queue.sv
design/lsu_agu.sv
design/lsu_data_ram.sv
design/lsu_tag_queue.sv
design/lsu_writeback.sv
design/lsu_cluster.sv
tests/lsu_cluster_assertions.sv
tests/lsu_cluster_tb.sv

//--- tests/lsu_cluster_assertions.sv
module lsu_cluster_assertions (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    flush_i,
    input logic                    dispatch_ready_o,
    input logic                    result_valid_o,
    input logic                    result_ready_i,
    input lsu_types_pkg::cdb_t     result_o,
    input lsu_ctrl_pkg::exc_code_e result_exc_o,
    input logic                    issue_valid,
    input logic                    issue_ready,
    input logic [3:0]              iq_count
);

timeunit 1ns;
timeprecision 1ps;

// ----------------------------------------------------------
// result channel
// ----------------------------------------------------------
result_stable_a: assert property (@(posedge clk) disable iff (reset_i || flush_i)
    result_valid_o && !result_ready_i |=>
        result_valid_o && $stable(result_o) && $stable(result_exc_o))
    else $error("result changed while stalled");

// a new result needs an issue two cycles before it
no_spurious_result_a: assert property (@(posedge clk) disable iff (reset_i)
    $rose(result_valid_o) |-> $past(issue_valid && issue_ready, 2))
    else $error("result without a preceding issue");

// ----------------------------------------------------------
// dispatch side
// ----------------------------------------------------------
no_accept_when_full_a: assert property (@(posedge clk) disable iff (reset_i)
    !dispatch_ready_o && !flush_i |=> iq_count <= $past(iq_count))
    else $error("issue queue grew while full");

endmodule

//--- tests/lsu_cluster_tb.sv
`include "lsu_consts.svh"

module lsu_cluster_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int TIMEOUT = 200;

typedef struct packed {
    logic [`LSU_ROB_ID_W-1:0] rob;
    logic [`LSU_XLEN-1:0]     data;
    logic [1:0]               exc;
} expect_t;

logic                         clk;
logic                         reset_i;
logic                         flush_i;
logic                         dispatch_valid_i;
logic                         dispatch_ready_o;
lsu_types_pkg::lsu_dispatch_t dispatch_i;
lsu_types_pkg::cdb_t          wakeup_i;
logic                         result_valid_o;
logic                         result_ready_i;
lsu_types_pkg::cdb_t          result_o;
lsu_ctrl_pkg::exc_code_e      result_exc_o;

expect_t sb_q[$];
int      cur_test;
int      err_test;
int      err_total;
int      results_test;
int      tests_run;
int      tests_failed;
bit      aborted;
string   test_names[6] = '{"none", "store_load", "wakeup", "backpressure_order",
                           "misalign", "flush"};

lsu_cluster dut0 (.*);

bind lsu_cluster lsu_cluster_assertions u_assert (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .dispatch_ready_o (dispatch_ready_o),
    .result_valid_o   (result_valid_o),
    .result_ready_i   (result_ready_i),
    .result_o         (result_o),
    .result_exc_o     (result_exc_o),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .iq_count         (u_iq.count_q)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// ----------------------------------------------------------
// result monitor with random back-pressure
// ----------------------------------------------------------
initial begin : result_monitor
    expect_t exp;
    void'($urandom(32'h8ca8));
    result_ready_i = 1'b1;
    forever begin
        @(negedge clk);
        result_ready_i = ($urandom % 4) != 0;
        #2;
        if (!reset_i && result_valid_o && result_ready_i) begin
            if (sb_q.size() == 0) begin
                $display("unexpected result for ROB id %h with nothing outstanding",
                         result_o.tag);
                err_test++;
            end else begin
                exp = sb_q.pop_front();
                results_test++;
                if (result_o.valid !== 1'b1) begin
                    $display("FAIL %s: result valid bit expected 1 actual %b",
                             test_names[cur_test], result_o.valid);
                    err_test++;
                end
                if (result_o.tag !== exp.rob) begin
                    $display("FAIL %s: rob id expected %h actual %h",
                             test_names[cur_test], exp.rob, result_o.tag);
                    err_test++;
                end
                if (result_o.data !== exp.data) begin
                    $display("FAIL %s: data expected %h actual %h",
                             test_names[cur_test], exp.data, result_o.data);
                    err_test++;
                end
                if (result_exc_o !== exp.exc) begin
                    $display("FAIL %s: exception expected %0d actual %0d",
                             test_names[cur_test], exp.exc, result_exc_o);
                    err_test++;
                end
            end
        end
    end
end

task automatic dispatch_op(input lsu_types_pkg::lsu_dispatch_t d);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!dispatch_ready_o && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (!dispatch_ready_o) begin
        $display("dispatch_ready_o stayed low, op was never accepted");
        aborted = 1'b1;
    end else begin
        dispatch_valid_i = 1'b1;
        dispatch_i       = d;
        @(negedge clk);
        dispatch_valid_i = 1'b0;
    end
endtask

// wait until every expected result has come back
task automatic drain_results();
    int waited;
    waited = 0;
    while (sb_q.size() != 0 && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (sb_q.size() != 0) begin
        $display("%0d results missing in test %s", sb_q.size(), test_names[cur_test]);
        aborted = 1'b1;
    end
endtask

task automatic check_quiet(input int cycles, input string what);
    repeat (cycles) begin
        @(negedge clk);
        if (result_valid_o) begin
            $display("a result appeared %s in test %s", what, test_names[cur_test]);
            err_test++;
        end
    end
endtask

task automatic broadcast(input logic [`LSU_ROB_ID_W-1:0] tag, input logic [`LSU_XLEN-1:0] data);
    @(negedge clk);
    wakeup_i.valid = 1'b1;
    wakeup_i.tag   = tag;
    wakeup_i.data  = data;
    @(negedge clk);
    wakeup_i.valid = 1'b0;
endtask

// ----------------------------------------------------------
// trace driven sequence
// ----------------------------------------------------------
initial begin : main_sequence
    int                           fd;
    int                           n;
    string                        line;
    logic [31:0]                  cmd, test, op, rob, imm, bdata, btag, brdy;
    logic [31:0]                  sdata, stag, srdy, wtag, wdata, edata, eexc;
    logic [`LSU_ROB_ID_W-1:0]     blocked_tag;
    lsu_types_pkg::lsu_dispatch_t d;
    expect_t                      e;

    reset_i          = 1'b1;
    flush_i          = 1'b0;
    dispatch_valid_i = 1'b0;
    dispatch_i       = '0;
    wakeup_i         = '0;
    blocked_tag      = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    fd = $fopen("tests/lsu_trace.txt", "r");
    if (fd == 0) begin
        $display("cannot open the trace file");
        aborted = 1'b1;
    end else begin
        while (!aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        cmd, test, op, rob, imm, bdata, btag, brdy,
                        sdata, stag, srdy, wtag, wdata, edata, eexc);
            if (n != 15) begin
                $display("malformed trace line: %s", line);
                aborted = 1'b1;
                continue;
            end
            cur_test         = int'(test);
            d.op             = lsu_ctrl_pkg::mem_op_e'(op[2:0]);
            d.rob_id         = rob[`LSU_ROB_ID_W-1:0];
            d.imm            = imm;
            d.base.data      = bdata;
            d.base.tag       = btag[`LSU_ROB_ID_W-1:0];
            d.base.ready     = brdy[0];
            d.sdata.data     = sdata;
            d.sdata.tag      = stag[`LSU_ROB_ID_W-1:0];
            d.sdata.ready    = srdy[0];
            e.rob            = rob[`LSU_ROB_ID_W-1:0];
            e.data           = edata;
            e.exc            = eexc[1:0];
            case (cmd)
                0: begin
                    sb_q.push_back(e);
                    dispatch_op(d);
                end
                1: begin
                    drain_results();
                    sb_q.push_back(e);
                    dispatch_op(d);
                    check_quiet(6, "before its wakeup");
                    broadcast(wtag[`LSU_ROB_ID_W-1:0], wdata);
                end
                2: begin
                    if (!brdy[0]) begin
                        blocked_tag = btag[`LSU_ROB_ID_W-1:0];
                    end
                    dispatch_op(d);
                end
                3: begin
                    @(negedge clk);
                    flush_i = 1'b1;
                    @(negedge clk);
                    flush_i = 1'b0;
                    if (!dispatch_ready_o) begin
                        $display("dispatch_ready_o low after flush");
                        err_test++;
                    end
                    // a stale entry would now wake and produce a result
                    broadcast(blocked_tag, '0);
                    check_quiet(6, "after flush");
                end
                default: begin
                    drain_results();
                    tests_run++;
                    if (err_test == 0 && !aborted) begin
                        $display("test %0d %s: pass, %0d results", cur_test,
                                 test_names[cur_test], results_test);
                    end else begin
                        $display("test %0d %s: fail, %0d errors", cur_test,
                                 test_names[cur_test], err_test);
                        tests_failed++;
                    end
                    err_total    += err_test;
                    err_test     = 0;
                    results_test = 0;
                end
            endcase
        end
        $fclose(fd);
    end

    err_total += err_test;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_total);
    if (!aborted && err_total == 0 && tests_failed == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

//--- tests/lsu_trace.txt
# cmd test op rob imm base btag brdy sdata stag srdy wtag wdata exp_data exp_exc (hex)
# cmd 0 op, 1 op woken later by wtag/wdata, 2 op to be flushed, 3 flush, 4 end of test
0 1 7 01 10 0 0 1 80817f01 0 1 0 0 0 0
0 1 2 02 10 0 0 1 0 0 1 0 0 80817f01 0
0 1 0 03 13 0 0 1 0 0 1 0 0 ffffff80 0
0 1 3 04 13 0 0 1 0 0 1 0 0 80 0
0 1 1 05 12 0 0 1 0 0 1 0 0 ffff8081 0
0 1 4 06 12 0 0 1 0 0 1 0 0 8081 0
0 1 0 07 10 0 0 1 0 0 1 0 0 1 0
0 1 6 08 22 0 0 1 beef 0 1 0 0 0 0
0 1 5 09 21 0 0 1 5a 0 1 0 0 0 0
0 1 2 0a 20 0 0 1 0 0 1 0 0 beef5a00 0
0 1 1 0b 20 0 0 1 0 0 1 0 0 5a00 0
0 1 3 0c 22 0 0 1 0 0 1 0 0 ef 0
4 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 2 2 0d 4 0 07 0 0 0 1 07 1c beef5a00 0
1 2 5 0e 30 0 0 1 0 09 0 09 77 0 0
0 2 3 0f 30 0 0 1 0 0 1 0 0 77 0
4 2 0 0 0 0 0 0 0 0 0 0 0 0 0
0 3 7 10 40 0 0 1 11223344 0 1 0 0 0 0
0 3 7 11 44 0 0 1 a5a5c3c3 0 1 0 0 0 0
0 3 2 12 40 0 0 1 0 0 1 0 0 11223344 0
0 3 1 13 46 0 0 1 0 0 1 0 0 ffffa5a5 0
0 3 3 14 41 0 0 1 0 0 1 0 0 33 0
0 3 5 15 40 0 0 1 ee 0 1 0 0 0 0
0 3 2 16 40 0 0 1 0 0 1 0 0 112233ee 0
0 3 0 17 44 0 0 1 0 0 1 0 0 ffffffc3 0
4 3 0 0 0 0 0 0 0 0 0 0 0 0 0
0 4 1 18 41 0 0 1 0 0 1 0 0 41 1
0 4 2 19 2 40 0 1 0 0 1 0 0 42 1
0 4 7 1a 45 0 0 1 deadbeef 0 1 0 0 45 2
0 4 2 1b 44 0 0 1 0 0 1 0 0 a5a5c3c3 0
4 4 0 0 0 0 0 0 0 0 0 0 0 0 0
2 5 2 1c 40 0 03 0 0 0 1 0 0 0 0
2 5 7 1d 40 0 0 1 0 0 1 0 0 0 0
3 5 0 0 0 0 0 0 0 0 0 0 0 0 0
0 5 2 1e 40 0 0 1 0 0 1 0 0 112233ee 0
4 5 0 0 0 0 0 0 0 0 0 0 0 0 0
